// ==== source/aluPkg.sv ====
`default_nettype none

package aluPkg;

    // Width of the function code field
    localparam int OpWidth = 6;

    // Integer function codes, float codes 1xxxxx are not decoded
    typedef enum logic [OpWidth-1:0] {
        opAdd  = 6'b000000,
        opSub  = 6'b000001,
        opMul  = 6'b000010,
        opSqrt = 6'b000011,
        opDiv  = 6'b000100,
        opMod  = 6'b000101,
        opSla  = 6'b000110,
        opSra  = 6'b000111,

        // Compares
        opEq   = 6'b001000,
        opNe   = 6'b001001,
        opGt   = 6'b001010,
        opLt   = 6'b001011,
        opGtu  = 6'b001100,
        opLtu  = 6'b001101,

        // Logic
        opNot  = 6'b010000,
        opAnd  = 6'b010001,
        opOr   = 6'b010010,
        opXor  = 6'b010011,
        opXnor = 6'b010100,
        opSll  = 6'b010110,
        opSrl  = 6'b010111
    } aluOp;

endpackage

`default_nettype wire

// ==== source/aluSequencer.sv ====
`default_nettype none

module aluSequencer #(
    parameter int DataWidth = 32
) (
    input  wire logic                 Reset,
    input  wire logic                 Clock,
    input  wire logic                 i_req,
    input  wire aluPkg::aluOp         i_op,
    input  wire logic [DataWidth-1:0] i_a,
    input  wire logic [DataWidth-1:0] i_b,
    input  wire logic [DataWidth-1:0] i_simpleResult,
    input  wire logic [DataWidth-1:0] i_divResult,
    input  wire logic                 i_divDone,
    input  wire logic [DataWidth-1:0] i_rootResult,
    input  wire logic                 i_rootDone,
    output aluPkg::aluOp              o_opReg,
    output logic [DataWidth-1:0]      o_aReg,
    output logic [DataWidth-1:0]      o_bReg,
    output logic                      o_divStart,
    output logic                      o_sqrtStart,
    output logic                      o_wantRemainder,
    output logic                      o_ack,
    output logic [DataWidth-1:0]      o_result
);

    localparam logic [1:0] StateIdle    = 2'd0;
    localparam logic [1:0] StateBusy    = 2'd1;   // Divider or root running
    localparam logic [1:0] StateCapture = 2'd2;
    localparam logic [1:0] StateHold    = 2'd3;   // Ack high until req drops

    logic [1:0] state;
    logic       unitDone;

    assign unitDone        = i_divDone | i_rootDone;
    assign o_wantRemainder = (o_opReg == aluPkg::opMod);

    // Operand latch on request acceptance
    always_ff @(posedge Reset) begin
        if (state == StateIdle && i_req) begin
            o_opReg <= i_op;
            o_aReg  <= i_a;
            o_bReg  <= i_b;
        end
    end

    always_ff @(posedge Reset or posedge Clock) begin
        if (Clock) begin
            state       <= StateIdle;
            o_divStart  <= 1'b0;
            o_sqrtStart <= 1'b0;
            o_ack       <= 1'b0;
            o_result    <= '0;
        end else begin
            o_divStart  <= 1'b0;    // Start lines are single pulses
            o_sqrtStart <= 1'b0;
            case (state)
                StateIdle: begin
                    if (i_req) begin
                        case (i_op)
                            aluPkg::opDiv, aluPkg::opMod: begin
                                o_divStart <= 1'b1;
                                state      <= StateBusy;
                            end
                            aluPkg::opSqrt: begin
                                o_sqrtStart <= 1'b1;
                                state       <= StateBusy;
                            end
                            default: state <= StateCapture;
                        endcase
                    end
                end
                StateBusy: begin
                    if (unitDone) state <= StateCapture;
                end
                StateCapture: begin
                    case (o_opReg)
                        aluPkg::opDiv, aluPkg::opMod: o_result <= i_divResult;
                        aluPkg::opSqrt:               o_result <= i_rootResult;
                        default:                      o_result <= i_simpleResult;
                    endcase
                    o_ack <= 1'b1;
                    state <= StateHold;
                end
                StateHold: begin
                    if (!i_req) begin
                        o_ack <= 1'b0;
                        state <= StateIdle;
                    end
                end
            endcase
        end
    end

    // Requester must drop req before ack may fall
    ackHoldsWhileReq: assert property (@(posedge Reset) disable iff (Clock)
        $fell(o_ack) |-> !$past(i_req));

    startOnlyFromIdle: assert property (@(posedge Reset) disable iff (Clock)
        (o_divStart || o_sqrtStart) |-> (state == StateBusy && $past(state) == StateIdle));

endmodule

`default_nettype wire

// ==== source/simpleOps.sv ====
`default_nettype none

module simpleOps #(
    parameter int DataWidth = 32
) (
    input  wire aluPkg::aluOp         i_op,
    input  wire logic [DataWidth-1:0] i_a,
    input  wire logic [DataWidth-1:0] i_b,
    output logic [DataWidth-1:0]      o_result
);

    localparam int ShiftBits = $clog2(DataWidth);

    logic [ShiftBits-1:0] shamt;

    assign shamt = i_b[ShiftBits-1:0];   // Larger amounts wrap

    always_comb begin
        o_result = '0;
        case (i_op)
            aluPkg::opAdd: o_result = i_a + i_b;
            aluPkg::opSub: o_result = i_a - i_b;
            aluPkg::opMul: o_result = i_a * i_b;   // Low word only

            // Arithmetic left shift is zero filled like the logical one
            aluPkg::opSla, aluPkg::opSll: begin
                o_result = i_a << shamt;
            end
            aluPkg::opSra: o_result = $signed(i_a) >>> shamt;
            aluPkg::opSrl: o_result = i_a >> shamt;

            // Flag in bit 0
            aluPkg::opEq: begin
                o_result[0] = (i_a == i_b);
            end
            aluPkg::opNe: begin
                o_result[0] = (i_a != i_b);
            end
            aluPkg::opGt: begin
                o_result[0] = ($signed(i_a) > $signed(i_b));
            end
            aluPkg::opLt: begin
                o_result[0] = ($signed(i_a) < $signed(i_b));
            end
            aluPkg::opGtu: begin
                o_result[0] = (i_a > i_b);
            end
            aluPkg::opLtu: begin
                o_result[0] = (i_a < i_b);
            end

            aluPkg::opNot:  o_result = ~i_a;
            aluPkg::opAnd:  o_result = i_a & i_b;
            aluPkg::opOr:   o_result = i_a | i_b;
            aluPkg::opXor:  o_result = i_a ^ i_b;
            aluPkg::opXnor: o_result = i_a ~^ i_b;

            // Multi-cycle and float codes
            default: o_result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/intDivider.sv ====
`default_nettype none

module intDivider #(
    parameter int DataWidth = 32
) (
    input  wire logic                 Reset,
    input  wire logic                 Clock,
    input  wire logic                 i_start,
    input  wire logic [DataWidth-1:0] i_dividend,
    input  wire logic [DataWidth-1:0] i_divisor,
    input  wire logic                 i_wantRemainder,
    output logic                      o_done,
    output logic [DataWidth-1:0]      o_result
);

    localparam int CountWidth = $clog2(DataWidth);

    localparam logic [1:0] StateIdle = 2'd0;
    localparam logic [1:0] StateSign = 2'd1;   // Take magnitudes
    localparam logic [1:0] StateLoop = 2'd2;
    localparam logic [1:0] StateFix  = 2'd3;   // Apply result sign

    logic [1:0]            state;
    logic [CountWidth-1:0] stepCount;
    logic [DataWidth-1:0]  dividendReg;
    logic [DataWidth-1:0]  divisorReg;
    logic                  wantRem;
    logic [DataWidth-1:0]  quo;         // Magnitude in, quotient out
    logic [DataWidth-1:0]  rem;
    logic [DataWidth-1:0]  den;
    logic [DataWidth:0]    shifted;
    logic [DataWidth:0]    diff;
    logic                  dividendNeg;
    logic                  divisorNeg;
    logic                  divByZero;
    logic [DataWidth-1:0]  fixedResult;

    assign dividendNeg = dividendReg[DataWidth-1];
    assign divisorNeg  = divisorReg[DataWidth-1];
    assign divByZero   = (divisorReg == '0);

    assign shifted = {rem, quo[DataWidth-1]};
    assign diff    = shifted - {1'b0, den};   // Top bit set means borrow

    always_comb begin
        if (divByZero) begin
            fixedResult = wantRem ? dividendReg : '1;
        end else if (wantRem) begin
            fixedResult = dividendNeg ? -rem : rem;   // Sign of the dividend
        end else begin
            fixedResult = (dividendNeg ^ divisorNeg) ? -quo : quo;
        end
    end

    always_ff @(posedge Reset or posedge Clock) begin
        if (Clock) begin
            state     <= StateIdle;
            stepCount <= '0;
            o_done    <= 1'b0;
        end else begin
            o_done <= 1'b0;
            case (state)
                StateIdle: begin
                    if (i_start) state <= StateSign;
                end
                StateSign: begin
                    stepCount <= CountWidth'(DataWidth - 1);
                    state     <= StateLoop;
                end
                StateLoop: begin
                    stepCount <= stepCount - 1'b1;
                    if (stepCount == '0) state <= StateFix;
                end
                StateFix: begin
                    o_done <= 1'b1;
                    state  <= StateIdle;
                end
            endcase
        end
    end

    always_ff @(posedge Reset) begin
        case (state)
            StateIdle: begin
                if (i_start) begin
                    dividendReg <= i_dividend;
                    divisorReg  <= i_divisor;
                    wantRem     <= i_wantRemainder;
                end
            end
            StateSign: begin
                quo <= dividendNeg ? -dividendReg : dividendReg;
                den <= divisorNeg ? -divisorReg : divisorReg;
                rem <= '0;
            end
            StateLoop: begin
                if (!diff[DataWidth]) begin
                    rem <= diff[DataWidth-1:0];
                    quo <= {quo[DataWidth-2:0], 1'b1};
                end else begin
                    rem <= shifted[DataWidth-1:0];   // Restore
                    quo <= {quo[DataWidth-2:0], 1'b0};
                end
            end
            StateFix: o_result <= fixedResult;
        endcase
    end

    // Sequencer never restarts a running division
    startWhileBusy: assert property (@(posedge Reset) disable iff (Clock)
        i_start |-> state == StateIdle);

endmodule

`default_nettype wire

// ==== source/intSqrt.sv ====
`default_nettype none

module intSqrt #(
    parameter int DataWidth = 32
) (
    input  wire logic                 Reset,
    input  wire logic                 Clock,
    input  wire logic                 i_start,
    input  wire logic [DataWidth-1:0] i_radicand,
    output logic                      o_done,
    output logic [DataWidth-1:0]      o_root
);

    localparam int Steps      = DataWidth / 2;   // One radicand bit pair each
    localparam int CountWidth = $clog2(Steps);
    localparam int RemWidth   = Steps + 2;

    localparam logic [1:0] StateIdle   = 2'd0;
    localparam logic [1:0] StateRun    = 2'd1;
    localparam logic [1:0] StateFinish = 2'd2;

    logic [1:0]            state;
    logic [CountWidth-1:0] stepCount;
    logic [DataWidth-1:0]  radShift;
    logic [Steps-1:0]      root;
    logic [RemWidth-1:0]   rem;
    logic [RemWidth+1:0]   pairRem;
    logic [RemWidth+1:0]   trial;
    logic                  fits;

    assign pairRem = {rem, radShift[DataWidth-1 -: 2]};
    assign trial   = {2'b00, root, 2'b01};   // 4*root + 1
    assign fits    = (pairRem >= trial);

    always_ff @(posedge Reset or posedge Clock) begin
        if (Clock) begin
            state     <= StateIdle;
            stepCount <= '0;
            o_done    <= 1'b0;
        end else begin
            o_done <= 1'b0;
            case (state)
                StateIdle: begin
                    if (i_start) begin
                        stepCount <= CountWidth'(Steps - 1);
                        state     <= StateRun;
                    end
                end
                StateRun: begin
                    stepCount <= stepCount - 1'b1;
                    if (stepCount == '0) state <= StateFinish;
                end
                default: begin
                    o_done <= 1'b1;
                    state  <= StateIdle;
                end
            endcase
        end
    end

    always_ff @(posedge Reset) begin
        if (state == StateIdle && i_start) begin
            radShift <= i_radicand;
            root     <= '0;
            rem      <= '0;
        end else if (state == StateRun) begin
            radShift <= radShift << 2;
            if (fits) begin
                rem  <= RemWidth'(pairRem - trial);
                root <= {root[Steps-2:0], 1'b1};
            end else begin
                rem  <= pairRem[RemWidth-1:0];
                root <= {root[Steps-2:0], 1'b0};
            end
        end else if (state == StateFinish) begin
            o_root <= {{(DataWidth-Steps){1'b0}}, root};
        end
    end

    startWhileBusy: assert property (@(posedge Reset) disable iff (Clock)
        i_start |-> state == StateIdle);

endmodule

`default_nettype wire

// ==== source/intAlu.sv ====
`default_nettype none

module intAlu #(
    parameter int DataWidth = 32
) (
    input  wire logic                 Reset,      // Clock
    input  wire logic                 Clock,      // Async reset, active high
    input  wire logic                 i_req,
    input  wire aluPkg::aluOp         i_op,
    input  wire logic [DataWidth-1:0] i_a,
    input  wire logic [DataWidth-1:0] i_b,
    output wire logic                 o_ack,
    output wire logic [DataWidth-1:0] o_result
);

    aluPkg::aluOp         opReg;
    logic [DataWidth-1:0] aReg;
    logic [DataWidth-1:0] bReg;
    logic                 divStart;
    logic                 sqrtStart;
    logic                 wantRemainder;
    logic [DataWidth-1:0] simpleResult;
    logic [DataWidth-1:0] divResult;
    logic                 divDone;
    logic [DataWidth-1:0] rootResult;
    logic                 rootDone;

    aluSequencer #(.DataWidth(DataWidth)) seq0 (
        .Reset           (Reset),
        .Clock           (Clock),
        .i_req           (i_req),
        .i_op            (i_op),
        .i_a             (i_a),
        .i_b             (i_b),
        .i_simpleResult  (simpleResult),
        .i_divResult     (divResult),
        .i_divDone       (divDone),
        .i_rootResult    (rootResult),
        .i_rootDone      (rootDone),
        .o_opReg         (opReg),
        .o_aReg          (aReg),
        .o_bReg          (bReg),
        .o_divStart      (divStart),
        .o_sqrtStart     (sqrtStart),
        .o_wantRemainder (wantRemainder),
        .o_ack           (o_ack),
        .o_result        (o_result)
    );

    simpleOps #(.DataWidth(DataWidth)) simple0 (
        .i_op     (opReg),
        .i_a      (aReg),
        .i_b      (bReg),
        .o_result (simpleResult)
    );

    intDivider #(.DataWidth(DataWidth)) div0 (
        .Reset           (Reset),
        .Clock           (Clock),
        .i_start         (divStart),
        .i_dividend      (aReg),
        .i_divisor       (bReg),
        .i_wantRemainder (wantRemainder),
        .o_done          (divDone),
        .o_result        (divResult)
    );

    intSqrt #(.DataWidth(DataWidth)) sqrt0 (
        .Reset      (Reset),
        .Clock      (Clock),
        .i_start    (sqrtStart),
        .i_radicand (aReg),
        .o_done     (rootDone),
        .o_root     (rootResult)
    );

endmodule

`default_nettype wire

// ==== tb/intAluTb.sv ====
`default_nettype none

module intAluTb;

    localparam int DataWidth   = 32;
    localparam int DriveDelay  = 10;    // After the rising edge
    localparam int ResetCycles = 3;
    localparam int HoldCycles  = 4;

    logic                 clk;
    logic                 rst;
    logic                 req;
    aluPkg::aluOp         op;
    logic [DataWidth-1:0] a;
    logic [DataWidth-1:0] b;
    logic                 ack;
    logic [DataWidth-1:0] result;

    logic [5:0]           traceOp[$];
    logic [DataWidth-1:0] traceA[$];
    logic [DataWidth-1:0] traceB[$];
    logic [DataWidth-1:0] traceExp[$];
    int                   cycleCount = 0;
    int                   cycleLimit = 0;
    int                   traceFd;

    intAlu #(.DataWidth(DataWidth)) dut0 (
        .Reset    (clk),    // Clock port of the DUT
        .Clock    (rst),
        .i_req    (req),
        .i_op     (op),
        .i_a      (a),
        .i_b      (b),
        .o_ack    (ack),
        .o_result (result)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic compare(input string name, input logic [DataWidth-1:0] expected,
                           input logic [DataWidth-1:0] actual);
        if (actual !== expected) begin
            $display("error: time %0t signal %s expected %h actual %h",
                     $time, name, expected, actual);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    task automatic nextCycle();
        @(posedge clk);
        #DriveDelay;
    endtask

    // Lines that do not hold four hex fields are skipped
    task automatic readTrace(input int fd);
        string                line;
        int                   count;
        logic [5:0]           opVal;
        logic [DataWidth-1:0] aVal;
        logic [DataWidth-1:0] bVal;
        logic [DataWidth-1:0] expVal;
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) > 0) begin
                count = $sscanf(line, "%h %h %h %h", opVal, aVal, bVal, expVal);
                if (count == 4) begin
                    traceOp.push_back(opVal);
                    traceA.push_back(aVal);
                    traceB.push_back(bVal);
                    traceExp.push_back(expVal);
                end
            end
        end
    endtask

    task automatic runOp(input int idx);
        int                   waited;
        logic                 multiCycle;
        multiCycle = (traceOp[idx] == aluPkg::opDiv) || (traceOp[idx] == aluPkg::opMod) ||
                     (traceOp[idx] == aluPkg::opSqrt);
        op     = aluPkg::aluOp'(traceOp[idx]);
        a      = traceA[idx];
        b      = traceB[idx];
        req    = 1'b1;
        waited = 0;
        do begin
            nextCycle();
            waited++;
            if (waited == 1) begin
                a = ~a;    // Operands already latched
                b = ~b;
            end
        end while (ack !== 1'b1);
        if (!multiCycle) compare("ack latency", 2, waited);
        compare("o_result", traceExp[idx], result);

        // Back-pressure on every fourth operation
        if (idx % 4 == 0) begin
            repeat (HoldCycles) begin
                nextCycle();
                compare("o_ack", 1'b1, ack);
                compare("o_result", traceExp[idx], result);
            end
        end
        req = 1'b0;
        nextCycle();
        compare("o_ack", 1'b0, ack);
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            abortRun($sformatf("Timeout after %0d cycles before the trace was done", cycleCount));
        end
    end

    initial begin
        rst = 1'b1;
        req = 1'b0;
        op  = aluPkg::opAdd;
        a   = '0;
        b   = '0;
        traceFd = $fopen("tb/aluTrace.txt", "r");
        if (traceFd == 0) begin
            abortRun("Could not open the trace file tb/aluTrace.txt");
        end else begin
            readTrace(traceFd);
            $fclose(traceFd);
            if (traceOp.size() == 0) begin
                abortRun("The trace file holds no operations");
            end else begin
                cycleLimit = ResetCycles + traceOp.size() * (DataWidth + 10);
                repeat (ResetCycles) @(posedge clk);
                #DriveDelay;
                rst = 1'b0;
                compare("o_ack", 1'b0, ack);
                compare("o_result", '0, result);
                foreach (traceOp[i]) runOp(i);
                $display("Finished with no errors");
                $finish;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb/aluTrace.txt ====
// op a b expected, all hex
// op codes follow aluPkg, 1xxxxx are unknown float codes
00 00000005 00000007 0000000c
00 7fffffff 00000001 80000000
01 00000003 00000005 fffffffe
01 80000000 00000001 7fffffff
02 00001234 00005678 06260060
02 ffffffff ffffffff 00000001
10 0f0f00ff 00000000 f0f0ff00
11 ff00ff00 0ff00ff0 0f000f00
12 ff00ff00 0ff00ff0 fff0fff0
13 ff00ff00 0ff00ff0 f0f0f0f0
14 ff00ff00 0ff00ff0 0f0f0f0f
16 00000001 0000001f 80000000
16 00000003 00000021 00000006
06 c0000001 00000004 00000010
07 80000000 0000001f ffffffff
07 f0000000 00000004 ff000000
17 80000000 0000001f 00000001
17 80000000 00000021 40000000
08 12345678 12345678 00000001
09 12345678 12345679 00000001
0a ffffffff 00000001 00000000
0c ffffffff 00000001 00000001
0b 80000000 00000000 00000001
0d 80000000 00000000 00000000
04 00000064 00000007 0000000e
05 00000064 00000007 00000002
04 ffffff9c 00000007 fffffff2
05 ffffff9c 00000007 fffffffe
04 00000064 fffffff9 fffffff2
05 00000064 fffffff9 00000002
04 00000005 00000000 ffffffff
05 00000005 00000000 00000005
04 80000000 ffffffff 80000000
05 80000000 ffffffff 00000000
03 00000000 00000000 00000000
03 00000001 00000000 00000001
03 00000090 00000000 0000000c
03 000000c8 00000000 0000000e
03 ffffffff 00000000 0000ffff
03 3b9aca00 00000000 00007b86
20 12345678 9abcdef0 00000000

// ==== intAlu.f ====
source/aluPkg.sv
source/aluSequencer.sv
source/simpleOps.sv
source/intDivider.sv
source/intSqrt.sv
source/intAlu.sv
tb/intAluTb.sv
